/* Bender.yml */
package:
  name: rv_exec

sources:
  - include_dirs:
      - hw
    files:
      - hw/rvPkg.sv
      - hw/control.sv
      - hw/immGen.sv
      - hw/execUnit.sv
      - hw/rvExecTop.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/tbRvExec.sv

/* flist.f */
+incdir+hw
hw/rvPkg.sv
hw/control.sv
hw/immGen.sv
hw/execUnit.sv
hw/rvExecTop.sv
testbench/tbRvExec.sv

/* hw/control.sv */
`timescale 1ns/1ps
`include "rvDefs_defs.svh"

module control (
	input  logic [`XLEN-1:0] instr,
	output logic             regWrite,
	output logic             memRead,
	output logic             memWrite,
	output logic             memToReg,
	output logic             aluSrcImm,
	output logic             aluSrcPc,
	output logic             illegal,
	output rvPkg::aluOpT     aluOp,
	output rvPkg::branchT    branchKind
);
	import rvPkg::*;

	opcodeT opcode;
	logic [2:0] funct3;
	logic altOp;
	logic funct7Ok;

	// Shared by register and immediate ALU forms
	function automatic aluOpT aluFromFunct3(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: aluFromFunct3 = alt ? aluSub : aluAdd;
			3'b001: aluFromFunct3 = aluSll;
			3'b010: aluFromFunct3 = aluSlt;
			3'b011: aluFromFunct3 = aluSltu;
			3'b100: aluFromFunct3 = aluXor;
			3'b101: aluFromFunct3 = alt ? aluSra : aluSrl;
			3'b110: aluFromFunct3 = aluOr;
			default: aluFromFunct3 = aluAnd;
		endcase
	endfunction

	assign opcode = opcodeT'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign altOp = instr[30];
	// Bit 30 is the only funct7 bit in use
	assign funct7Ok = (instr[31:25] & 7'b1011111) == 7'b0;

	always_comb begin
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		aluSrcImm = 1'b0;
		aluSrcPc = 1'b0;
		illegal = 1'b0;
		aluOp = aluAdd;
		branchKind = brNone;
		case (opcode)
			opOp: begin
				if (funct7Ok && (!altOp || funct3 == 3'b000 || funct3 == 3'b101)) begin
					regWrite = 1'b1;
					aluOp = aluFromFunct3(funct3, altOp);
				end else begin
					illegal = 1'b1;
				end
			end
			opOpImm: begin
				if (funct3 == 3'b001 && !(funct7Ok && !altOp)) begin
					illegal = 1'b1;
				end else if (funct3 == 3'b101 && !funct7Ok) begin
					illegal = 1'b1;
				end else begin
					regWrite = 1'b1;
					aluSrcImm = 1'b1;
					// For ADDI bit 30 belongs to the immediate
					aluOp = aluFromFunct3(funct3, altOp && funct3 == 3'b101);
				end
			end
			opLui: begin
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				aluOp = aluPassB;
			end
			opAuipc: begin
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				aluSrcPc = 1'b1;
			end
			opLoad: begin
				if (funct3 == 3'b010) begin
					regWrite = 1'b1;
					memRead = 1'b1;
					memToReg = 1'b1;
					aluSrcImm = 1'b1;
				end else begin
					illegal = 1'b1;
				end
			end
			opStore: begin
				if (funct3 == 3'b010) begin
					memWrite = 1'b1;
					aluSrcImm = 1'b1;
				end else begin
					illegal = 1'b1;
				end
			end
			opJal: begin
				regWrite = 1'b1;
				branchKind = brJal;
			end
			opJalr: begin
				if (funct3 == 3'b000) begin
					regWrite = 1'b1;
					branchKind = brJalr;
				end else begin
					illegal = 1'b1;
				end
			end
			opBranch: begin
				case (funct3)
					3'b000: branchKind = brEq;
					3'b001: branchKind = brNe;
					3'b100: branchKind = brLt;
					3'b101: branchKind = brGe;
					3'b110: branchKind = brLtu;
					3'b111: branchKind = brGeu;
					default: illegal = 1'b1;
				endcase
			end
			default: illegal = 1'b1;
		endcase
	end

endmodule

/* hw/execUnit.sv */
`timescale 1ns/1ps
`include "rvDefs_defs.svh"

module execUnit (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  instrStrobe,
	input  logic [`XLEN-1:0]      pc,
	input  logic [`XLEN-1:0]      rs1Data,
	input  logic [`XLEN-1:0]      rs2Data,
	input  logic [`XLEN-1:0]      imm,
	input  logic [`XLEN-1:0]      instr,
	input  logic                  regWriteIn,
	input  logic                  memReadIn,
	input  logic                  memWriteIn,
	input  logic                  memToRegIn,
	input  logic                  aluSrcImm,
	input  logic                  aluSrcPc,
	input  logic                  illegalIn,
	input  rvPkg::aluOpT          aluOp,
	input  rvPkg::branchT         branchKind,
	output logic                  resultValid,
	output logic [`XLEN-1:0]      result,
	output logic [`XLEN-1:0]      nextPc,
	output logic [`REG_IDX_W-1:0] rd,
	output logic                  regWrite,
	output logic                  memRead,
	output logic                  memWrite,
	output logic                  memToReg,
	output logic                  illegal
);
	import rvPkg::*;

	logic [`XLEN-1:0] opA;
	logic [`XLEN-1:0] opB;
	logic [4:0] shamt;
	logic [`XLEN-1:0] aluResult;
	logic [`XLEN-1:0] pcPlus4;
	logic [`XLEN-1:0] jalrTarget;
	logic isJump;
	logic taken;

	assign opA = aluSrcPc ? pc : rs1Data;
	assign opB = aluSrcImm ? imm : rs2Data;
	assign shamt = opB[4:0];

	always_comb begin
		case (aluOp)
			aluSub: aluResult = opA - opB;
			aluAnd: aluResult = opA & opB;
			aluOr: aluResult = opA | opB;
			aluXor: aluResult = opA ^ opB;
			aluSlt: aluResult = {31'b0, $signed(opA) < $signed(opB)};
			aluSltu: aluResult = {31'b0, opA < opB};
			aluSll: aluResult = opA << shamt;
			aluSrl: aluResult = opA >> shamt;
			aluSra: aluResult = $signed(opA) >>> shamt;
			aluPassB: aluResult = opB;
			default: aluResult = opA + opB;
		endcase
	end

	// Branch compare always uses the register operands
	always_comb begin
		case (branchKind)
			brEq: taken = rs1Data == rs2Data;
			brNe: taken = rs1Data != rs2Data;
			brLt: taken = $signed(rs1Data) < $signed(rs2Data);
			brGe: taken = $signed(rs1Data) >= $signed(rs2Data);
			brLtu: taken = rs1Data < rs2Data;
			brGeu: taken = rs1Data >= rs2Data;
			brJal: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign pcPlus4 = pc + 32'd4;
	assign jalrTarget = (rs1Data + imm) & ~32'd1;
	assign isJump = branchKind == brJal || branchKind == brJalr;

	always_ff @(posedge clk) begin
		if (reset) begin
			resultValid <= 1'b0;
			regWrite <= 1'b0;
			memRead <= 1'b0;
			memWrite <= 1'b0;
			memToReg <= 1'b0;
			illegal <= 1'b0;
		end else begin
			resultValid <= instrStrobe;
			if (instrStrobe) begin
				regWrite <= regWriteIn;
				memRead <= memReadIn;
				memWrite <= memWriteIn;
				memToReg <= memToRegIn;
				illegal <= illegalIn;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (instrStrobe) begin
			result <= isJump ? pcPlus4 : aluResult;
			if (branchKind == brJalr)
				nextPc <= jalrTarget;
			else
				nextPc <= taken ? pc + imm : pcPlus4;
			rd <= regWriteIn ? instr[11:7] : '0;
		end
	end

	// A decoded instruction never both loads and stores
	memExclusive: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> !(memRead && memWrite))
		else $error("memRead and memWrite both set on a result");

	// Rejected encodings must not reach the register file or memory
	illegalNoSideEffect: assert property (@(posedge clk) disable iff (reset)
		(resultValid && illegal) |-> !(regWrite || memRead || memWrite))
		else $error("illegal instruction drives a write or read enable");

endmodule

/* hw/immGen.sv */
`timescale 1ns/1ps
`include "rvDefs_defs.svh"

module immGen (
	input  logic [`XLEN-1:0] instr,
	output logic [`XLEN-1:0] imm
);
	import rvPkg::*;

	opcodeT opcode;

	assign opcode = opcodeT'(instr[6:0]);

	always_comb begin
		case (opcode)
			opOpImm, opLoad, opJalr: begin
				imm = {{20{instr[31]}}, instr[31:20]};
			end
			opStore: begin
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			end
			opBranch: begin
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			end
			opLui, opAuipc: begin
				imm = {instr[31:12], 12'b0};
			end
			opJal: begin
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			end
			// R-type and unknown opcodes
			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

/* hw/rvDefs_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Data and address width
`define XLEN 32

// Register index width
`define REG_IDX_W 5

`endif

/* hw/rvExecTop.sv */
`timescale 1ns/1ps
`include "rvDefs_defs.svh"

module rvExecTop (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  instrStrobe,
	input  logic [`XLEN-1:0]      instr,
	input  logic [`XLEN-1:0]      pc,
	input  logic [`XLEN-1:0]      rs1Data,
	input  logic [`XLEN-1:0]      rs2Data,
	output logic                  resultValid,
	output logic [`XLEN-1:0]      result,
	output logic [`XLEN-1:0]      nextPc,
	output logic [`REG_IDX_W-1:0] rd,
	output logic                  regWrite,
	output logic                  memRead,
	output logic                  memWrite,
	output logic                  memToReg,
	output logic                  illegal
);
	import rvPkg::*;

	logic decRegWrite;
	logic decMemRead;
	logic decMemWrite;
	logic decMemToReg;
	logic aluSrcImm;
	logic aluSrcPc;
	logic decIllegal;
	aluOpT aluOp;
	branchT branchKind;
	logic [`XLEN-1:0] imm;

	control controlInst (
		.instr      (instr),
		.regWrite   (decRegWrite),
		.memRead    (decMemRead),
		.memWrite   (decMemWrite),
		.memToReg   (decMemToReg),
		.aluSrcImm  (aluSrcImm),
		.aluSrcPc   (aluSrcPc),
		.illegal    (decIllegal),
		.aluOp      (aluOp),
		.branchKind (branchKind)
	);

	immGen immGenInst (
		.instr (instr),
		.imm   (imm)
	);

	execUnit execUnitInst (
		.clk         (clk),
		.reset       (reset),
		.instrStrobe (instrStrobe),
		.pc          (pc),
		.rs1Data     (rs1Data),
		.rs2Data     (rs2Data),
		.imm         (imm),
		.instr       (instr),
		.regWriteIn  (decRegWrite),
		.memReadIn   (decMemRead),
		.memWriteIn  (decMemWrite),
		.memToRegIn  (decMemToReg),
		.aluSrcImm   (aluSrcImm),
		.aluSrcPc    (aluSrcPc),
		.illegalIn   (decIllegal),
		.aluOp       (aluOp),
		.branchKind  (branchKind),
		.resultValid (resultValid),
		.result      (result),
		.nextPc      (nextPc),
		.rd          (rd),
		.regWrite    (regWrite),
		.memRead     (memRead),
		.memWrite    (memWrite),
		.memToReg    (memToReg),
		.illegal     (illegal)
	);

endmodule

/* hw/rvPkg.sv */
package rvPkg;

	// Major opcodes of the supported RV32I subset
	typedef enum logic [6:0] {
		opOp     = 7'b0110011,
		opOpImm  = 7'b0010011,
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111,
		opBranch = 7'b1100011
	} opcodeT;

	typedef enum logic [3:0] {
		aluAdd   = 4'd0,
		aluSub   = 4'd1,
		aluAnd   = 4'd2,
		aluOr    = 4'd3,
		aluXor   = 4'd4,
		aluSlt   = 4'd5,
		aluSltu  = 4'd6,
		aluSll   = 4'd7,
		aluSrl   = 4'd8,
		aluSra   = 4'd9,
		aluPassB = 4'd10
	} aluOpT;

	// Nine kinds, so four bits
	typedef enum logic [3:0] {
		brNone = 4'd0,
		brEq   = 4'd1,
		brNe   = 4'd2,
		brLt   = 4'd3,
		brGe   = 4'd4,
		brLtu  = 4'd5,
		brGeu  = 4'd6,
		brJal  = 4'd7,
		brJalr = 4'd8
	} branchT;

endpackage

/* testbench/tbRvExec.sv */
`timescale 1ns/1ps
`include "rvDefs_defs.svh"

module tbRvExec;

	localparam int CLK_PERIOD = 10;
	localparam int SWEEP_COUNT = 48;
	localparam int BURST_LEN = 6;

	typedef struct {
		string name;
		logic [`XLEN-1:0] instr;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] rs1;
		logic [`XLEN-1:0] rs2;
		bit checkRes;
		logic [`XLEN-1:0] result;
		logic [`XLEN-1:0] nextPc;
		logic [`REG_IDX_W-1:0] rd;
		// regWrite, memRead, memWrite, memToReg, illegal
		logic [4:0] ctl;
	} vecT;

	logic clk;
	logic reset;
	logic instrStrobe;
	logic [`XLEN-1:0] instr;
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] rs1Data;
	logic [`XLEN-1:0] rs2Data;
	logic resultValid;
	logic [`XLEN-1:0] result;
	logic [`XLEN-1:0] nextPc;
	logic [`REG_IDX_W-1:0] rd;
	logic regWrite;
	logic memRead;
	logic memWrite;
	logic memToReg;
	logic illegal;

	vecT vecs[$];
	bit vecsReady = 1'b0;
	logic [15:0] lfsrState = 16'd39868;

	rvExecTop DUT (
		.clk         (clk),
		.reset       (reset),
		.instrStrobe (instrStrobe),
		.instr       (instr),
		.pc          (pc),
		.rs1Data     (rs1Data),
		.rs2Data     (rs2Data),
		.resultValid (resultValid),
		.result      (result),
		.nextPc      (nextPc),
		.rd          (rd),
		.regWrite    (regWrite),
		.memRead     (memRead),
		.memWrite    (memWrite),
		.memToReg    (memToReg),
		.illegal     (illegal)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input logic [`XLEN-1:0] exp,
			input logic [`XLEN-1:0] act);
		if (act !== exp)
			abortRun($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic checkIdx(input string name, input logic [`REG_IDX_W-1:0] exp,
			input logic [`REG_IDX_W-1:0] act);
		if (act !== exp)
			abortRun($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		if (act !== exp)
			abortRun($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
	endtask

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] val;
		logic outBit;
		val = '0;
		for (int k = 0; k < n; k++) begin
			outBit = lfsrState[0];
			lfsrState = lfsrState >> 1;
			if (outBit)
				lfsrState = lfsrState ^ 16'hB400;
			val = {val[30:0], outBit};
		end
		return val;
	endfunction

	function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rdIdx);
		return {f7, rs2, rs1, f3, rdIdx, 7'b0110011};
	endfunction

	function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rdIdx, input logic [6:0] op);
		return {imm, rs1, f3, rdIdx, op};
	endfunction

	function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rdIdx,
			input logic [6:0] op);
		return {imm, rdIdx, op};
	endfunction

	function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rdIdx);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rdIdx, 7'b1101111};
	endfunction

	// RV32I integer ops by funct3, alt selects SUB or SRA
	function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		logic [4:0] sh;
		sh = b[4:0];
		case (f3)
			3'd0: refAlu = alt ? a - b : a + b;
			3'd1: refAlu = a << sh;
			3'd2: refAlu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: refAlu = (a < b) ? 32'd1 : 32'd0;
			3'd4: refAlu = a ^ b;
			3'd5: begin
				if (alt)
					refAlu = $signed(a) >>> sh;
				else
					refAlu = a >> sh;
			end
			3'd6: refAlu = a | b;
			default: refAlu = a & b;
		endcase
	endfunction

	task automatic addVec(input string name, input logic [31:0] ins, input logic [31:0] pcVal,
			input logic [31:0] a, input logic [31:0] b, input bit chk,
			input logic [31:0] res, input logic [31:0] npc, input logic [4:0] rdIdx,
			input logic [4:0] ctl);
		vecT v;
		v.name = name;
		v.instr = ins;
		v.pc = pcVal;
		v.rs1 = a;
		v.rs2 = b;
		v.checkRes = chk;
		v.result = res;
		v.nextPc = npc;
		v.rd = rdIdx;
		v.ctl = ctl;
		vecs.push_back(v);
	endtask

	task automatic buildTable();
		// First BURST_LEN entries are reused back to back
		addVec("add", rType(0, 2, 1, 0, 5), 'h100, 10, 20, 1, 'h1E, 'h104, 5, 5'b10000);
		addVec("sub", rType(32, 2, 1, 0, 6), 'h100, 5, 7, 1, 'hFFFFFFFE, 'h104, 6, 5'b10000);
		addVec("slt", rType(0, 2, 1, 2, 7), 'h100, 'hFFFFFFFF, 1, 1, 1, 'h104, 7, 5'b10000);
		addVec("sltu", rType(0, 2, 1, 3, 8), 'h100, 'hFFFFFFFF, 1, 1, 0, 'h104, 8, 5'b10000);
		addVec("sra", rType(32, 2, 1, 5, 9), 'h100, 'h80000000, 4, 1, 'hF8000000, 'h104, 9,
			5'b10000);
		addVec("srl", rType(0, 2, 1, 5, 10), 'h100, 'h80000000, 4, 1, 'h08000000, 'h104, 10,
			5'b10000);
		addVec("sll", rType(0, 2, 1, 1, 11), 'h104, 1, 33, 1, 2, 'h108, 11, 5'b10000);
		addVec("xor", rType(0, 2, 1, 4, 12), 'h104, 'hF0F0F0F0, 'h0FF00FF0, 1, 'hFF00FF00,
			'h108, 12, 5'b10000);
		addVec("addi", iType('hFFF, 1, 0, 13, 'h13), 'h200, 5, 0, 1, 4, 'h204, 13, 5'b10000);
		addVec("sltiu", iType('hFFF, 1, 3, 14, 'h13), 'h200, 3, 0, 1, 1, 'h204, 14, 5'b10000);
		addVec("slti", iType('hFFF, 1, 2, 15, 'h13), 'h200, 3, 0, 1, 0, 'h204, 15, 5'b10000);
		addVec("srai", iType('h408, 1, 5, 16, 'h13), 'h200, 'h80000000, 0, 1, 'hFF800000,
			'h204, 16, 5'b10000);
		addVec("andi", iType('h0F0, 1, 7, 17, 'h13), 'h200, 'h12345678, 0, 1, 'h70, 'h204, 17,
			5'b10000);
		addVec("ori", iType('h800, 1, 6, 18, 'h13), 'h200, 'h12345678, 0, 1, 'hFFFFFE78,
			'h204, 18, 5'b10000);
		addVec("lui", uType('h12345, 3, 'h37), 'h300, 0, 0, 1, 'h12345000, 'h304, 3, 5'b10000);
		addVec("auipc", uType(1, 4, 'h17), 'h1000, 0, 0, 1, 'h2000, 'h1004, 4, 5'b10000);
		addVec("lw", iType('hFFC, 1, 2, 7, 'h03), 'h300, 'h100, 0, 1, 'hFC, 'h304, 7, 5'b11010);
		addVec("sw", sType('h010, 2, 1), 'h300, 'h200, 9, 1, 'h210, 'h304, 0, 5'b00100);
		addVec("beq taken", bType(16, 2, 1, 0), 'h400, 5, 5, 0, 0, 'h410, 0, 5'b00000);
		addVec("beq not", bType(16, 2, 1, 0), 'h400, 5, 6, 0, 0, 'h404, 0, 5'b00000);
		addVec("bne taken", bType(16, 2, 1, 1), 'h400, 5, 6, 0, 0, 'h410, 0, 5'b00000);
		addVec("bne not", bType(16, 2, 1, 1), 'h400, 5, 5, 0, 0, 'h404, 0, 5'b00000);
		addVec("blt taken", bType('h1FF8, 2, 1, 4), 'h400, 'hFFFFFFFF, 1, 0, 0, 'h3F8, 0, 5'b0);
		addVec("blt not", bType(16, 2, 1, 4), 'h400, 1, 'hFFFFFFFF, 0, 0, 'h404, 0, 5'b0);
		addVec("bge taken", bType(16, 2, 1, 5), 'h400, 1, 'hFFFFFFFF, 0, 0, 'h410, 0, 5'b0);
		addVec("bge not", bType(16, 2, 1, 5), 'h400, 'hFFFFFFFF, 1, 0, 0, 'h404, 0, 5'b0);
		addVec("bltu taken", bType(16, 2, 1, 6), 'h400, 1, 'hFFFFFFFF, 0, 0, 'h410, 0, 5'b0);
		addVec("bltu not", bType(16, 2, 1, 6), 'h400, 'hFFFFFFFF, 1, 0, 0, 'h404, 0, 5'b0);
		addVec("bgeu taken", bType(16, 2, 1, 7), 'h400, 'hFFFFFFFF, 1, 0, 0, 'h410, 0, 5'b0);
		addVec("bgeu not", bType(16, 2, 1, 7), 'h400, 1, 'hFFFFFFFF, 0, 0, 'h404, 0, 5'b0);
		addVec("jal", jType('h100, 1), 'h800, 0, 0, 1, 'h804, 'h900, 1, 5'b10000);
		addVec("jal back", jType('h1FFFE0, 1), 'h800, 0, 0, 1, 'h804, 'h7E0, 1, 5'b10000);
		addVec("jalr", iType(5, 1, 0, 1, 'h67), 'h800, 'h1000, 0, 1, 'h804, 'h1004, 1, 5'b10000);
		addVec("bad opcode", 'h0000007F, 'h800, 0, 0, 0, 0, 'h804, 0, 5'b00001);
		addVec("lh", iType(0, 1, 1, 2, 'h03), 'h800, 0, 0, 0, 0, 'h804, 0, 5'b00001);
		addVec("mul", rType(1, 2, 1, 0, 5), 'h800, 3, 4, 0, 0, 'h804, 0, 5'b00001);
	endtask

	task automatic driveInputs(input vecT v);
		instr = v.instr;
		pc = v.pc;
		rs1Data = v.rs1;
		rs2Data = v.rs2;
		instrStrobe = 1'b1;
	endtask

	task automatic checkOutputs(input vecT v);
		if (v.checkRes)
			checkWord({v.name, " result"}, v.result, result);
		checkWord({v.name, " nextPc"}, v.nextPc, nextPc);
		checkIdx({v.name, " rd"}, v.rd, rd);
		checkBit({v.name, " regWrite"}, v.ctl[4], regWrite);
		checkBit({v.name, " memRead"}, v.ctl[3], memRead);
		checkBit({v.name, " memWrite"}, v.ctl[2], memWrite);
		checkBit({v.name, " memToReg"}, v.ctl[1], memToReg);
		checkBit({v.name, " illegal"}, v.ctl[0], illegal);
	endtask

	task automatic applyVec(input vecT v);
		@(negedge clk);
		driveInputs(v);
		@(negedge clk);
		instrStrobe = 1'b0;
		if (resultValid !== 1'b1)
			abortRun($sformatf("%s: resultValid did not rise one cycle after the strobe",
				v.name));
		checkOutputs(v);
	endtask

	task automatic runSweep();
		vecT v;
		logic isImm;
		logic [2:0] f3;
		logic alt;
		logic [4:0] rdIdx;
		logic [11:0] imm12;
		logic [`XLEN-1:0] opB;
		for (int i = 0; i < SWEEP_COUNT; i++) begin
			isImm = 1'(takeBits(1));
			f3 = 3'(takeBits(3));
			alt = 1'(takeBits(1));
			rdIdx = 5'(takeBits(5));
			imm12 = 12'(takeBits(12));
			v.pc = takeBits(30) << 2;
			v.rs1 = takeBits(32);
			v.rs2 = takeBits(32);
			if (isImm) begin
				if (f3 != 3'd5)
					alt = 1'b0;
				// Shift immediates carry only shamt and the SRAI bit
				if (f3 == 3'd1 || f3 == 3'd5)
					imm12[11:5] = alt ? 7'b0100000 : 7'b0;
				v.instr = iType(imm12, 1, f3, rdIdx, 'h13);
				opB = {{20{imm12[11]}}, imm12};
			end else begin
				if (f3 != 3'd0 && f3 != 3'd5)
					alt = 1'b0;
				v.instr = rType(alt ? 7'b0100000 : 7'b0, 2, 1, f3, rdIdx);
				opB = v.rs2;
			end
			v.name = $sformatf("sweep %0d", i);
			v.checkRes = 1'b1;
			v.result = refAlu(f3, alt, v.rs1, opB);
			v.nextPc = v.pc + 32'd4;
			v.rd = rdIdx;
			v.ctl = 5'b10000;
			applyVec(v);
		end
	endtask

	// One strobe per cycle, each result due on the following cycle
	task automatic runBurst();
		for (int i = 0; i <= BURST_LEN; i++) begin
			@(negedge clk);
			if (i > 0) begin
				if (resultValid !== 1'b1)
					abortRun($sformatf("burst: no resultValid one cycle after strobe %0d", i - 1));
				checkOutputs(vecs[i - 1]);
			end
			if (i < BURST_LEN)
				driveInputs(vecs[i]);
			else
				instrStrobe = 1'b0;
		end
		@(negedge clk);
		checkBit("burst end resultValid", 1'b0, resultValid);
	endtask

	initial begin
		wait (vecsReady);
		#((vecs.size() + SWEEP_COUNT + 10) * 2 * CLK_PERIOD);
		abortRun("timeout: the tests did not finish in the expected time");
	end

	initial begin
		reset = 1'b1;
		instrStrobe = 1'b0;
		instr = '0;
		pc = '0;
		rs1Data = '0;
		rs2Data = '0;
		buildTable();
		vecsReady = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		checkBit("reset resultValid", 1'b0, resultValid);
		checkBit("reset regWrite", 1'b0, regWrite);
		checkBit("reset memRead", 1'b0, memRead);
		checkBit("reset memWrite", 1'b0, memWrite);
		foreach (vecs[i])
			applyVec(vecs[i]);
		runSweep();
		runBurst();
		$display("Regression passed");
		$finish;
	end

endmodule
